/* dv/iq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_checker import pip_pkg::*; #(
  parameter int DEPTH       = 16,
  parameter int GROUP_WIDTH = 4
) (
  input  wire logic                                 clock,
  input  wire logic                                 reset_n,
  input  wire logic                                 flush_i,
  input  wire logic                                 dec_valid_i,
  input  wire logic      [$clog2(GROUP_WIDTH)-1:0]  dec_count_i,
  input  wire dec_inst_t [GROUP_WIDTH-1:0]          dec_group_i,
  input  wire logic                                 issue_ready_i,
  input  wire issue_bundle_t                        issue_i,
  input  wire logic                                 full_i,
  input  wire logic                                 empty_i,
  input  wire logic      [$clog2(DEPTH):0]          used_i,
  input  wire logic                                 test_end_i,
  input  wire logic      [8*16-1:0]                 test_name_i,
  input  wire logic      [31:0]                     exp_issued_i,
  input  wire logic                                 done_i,
  output logic                                      drained_o,
  output int                                        errors_o
);

  iq_entry_t               mq[$];               // Model queue with the oldest entry first.
  iq_entry_t [ISSUE_W-1:0] exp_lanes;
  logic      [ISSUE_W-1:0] exp_mask    = '0;
  logic                    fresh       = 1'b0;  // A new bundle is on the issue port.
  logic                    drained     = 1'b1;
  int                      next_slot   = 0;
  int                      errors      = 0;
  int                      test_errors = 0;
  int                      test_issued = 0;
  int                      tests       = 0;
  int                      accepted    = 0;
  int                      issued      = 0;
  int                      flushed     = 0;

  assign drained_o = drained;
  assign errors_o  = errors;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %0t: %0s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic int count_selected();
    int n;
    n = 0;
    if (mq.size() > 0 && mq[0].dec_inst.serial) begin
      n = 1;   // Serializing instruction leaves alone.
    end else begin
      while (n < ISSUE_W && n < mq.size() && !mq[n].dec_inst.serial) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic compare_outputs();
    int k;
    check_value("issue mask", 32'(issue_i.valid), 32'(exp_mask));
    for (k = 0; k < ISSUE_W; k++) begin
      if (exp_mask[k]) begin
        check_value($sformatf("lane %0d pc", k), issue_i.entries[k].dec_inst.pc,
                    exp_lanes[k].dec_inst.pc);
        check_value($sformatf("lane %0d inst_word", k), issue_i.entries[k].dec_inst.inst_word,
                    exp_lanes[k].dec_inst.inst_word);
        check_value($sformatf("lane %0d rob_slot", k), 32'(issue_i.entries[k].rob_slot),
                    32'(exp_lanes[k].rob_slot));
      end
    end
    check_value("used count", 32'(used_i), 32'(mq.size()));
    check_value("empty flag", 32'(empty_i), 32'(mq.size() == 0));
    check_value("full flag", 32'(full_i), 32'(mq.size() > DEPTH - GROUP_WIDTH));
    if (fresh) begin
      issued      += $countones(issue_i.valid);
      test_issued += $countones(issue_i.valid);
    end
  endtask

  task automatic advance_model();
    int        n;
    int        k;
    int        size_before;
    iq_entry_t e;
    fresh       = 1'b0;
    size_before = mq.size();
    if (flush_i) begin
      flushed  += size_before;
      mq.delete();
      exp_mask  = '0;
      next_slot = 0;
    end else begin
      if (issue_ready_i) begin
        n        = count_selected();
        exp_mask = '0;
        for (k = 0; k < n; k++) begin
          exp_lanes[k] = mq.pop_front();
          exp_mask[k]  = 1'b1;
        end
        fresh = (n > 0);
      end
      if (dec_valid_i && size_before <= DEPTH - GROUP_WIDTH) begin   // Full uses the old count.
        for (k = 0; k <= int'(dec_count_i); k++) begin
          e.dec_inst = dec_group_i[k];
          e.rob_slot = ROB_SLOT_W'(next_slot);
          next_slot  = (next_slot + 1) % (1 << ROB_SLOT_W);
          mq.push_back(e);
          accepted++;
        end
      end
    end
    drained = (mq.size() == 0) && (exp_mask == '0);
  endtask

  task automatic report_test();
    if (test_issued != int'(exp_issued_i)) begin
      $display("FAILED %0t: test %0s issued %0d instructions, expected %0d", $time,
               test_name_i, test_issued, exp_issued_i);
      errors++;
    end
    $display("test %0s: %0d issued, %0s", test_name_i, test_issued,
             (errors == test_errors) ? "passed" : "failed");
    tests++;
    test_issued = 0;
    test_errors = errors;
  endtask

  task automatic report_totals();
    if (accepted != issued + flushed) begin
      $display("Stimulus not fully consumed: %0d accepted, %0d issued, %0d flushed",
               accepted, issued, flushed);
      errors++;
    end
    $display("%0d tests, %0d accepted, %0d issued, %0d flushed, %0d errors",
             tests, accepted, issued, flushed, errors);
  endtask

  // Inputs and outputs are both settled at the falling edge.
  always @(negedge clock) begin
    if (!reset_n) begin
      mq.delete();
      exp_mask  = '0;
      fresh     = 1'b0;
      next_slot = 0;
      drained   = 1'b1;
    end else begin
      compare_outputs();
      if (test_end_i) begin
        report_test();
      end
      if (done_i) begin
        report_totals();
      end
      advance_model();
    end
  end

endmodule

`default_nettype wire

/* dv/iq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_tb import pip_pkg::*; ();

  localparam int IQ_DEPTH    = 16;
  localparam int GROUP_WIDTH = 4;
  localparam int TIMEOUT     = 200;

  logic                        clock = 1'b0;
  logic                        reset_n;
  logic                        flush;
  logic                        dec_valid;
  logic [1:0]                  dec_count;
  dec_inst_t [GROUP_WIDTH-1:0] dec_group;
  logic                        issue_ready;
  issue_bundle_t               issue;
  logic                        iq_full;
  logic                        iq_empty;
  logic [$clog2(IQ_DEPTH):0]   iq_used;
  logic                        test_end;
  logic                        run_done;
  logic [8*16-1:0]             test_name;
  logic [31:0]                 exp_issued;
  logic                        drained;
  int                          chk_errors;
  logic [31:0]                 lfsr = 32'h46f3;
  logic [31:0]                 v_flush;
  logic [31:0]                 v_valid;
  logic [31:0]                 v_count;
  logic [31:0]                 v_serial;
  logic [31:0]                 v_ready;
  logic [31:0]                 pcs [GROUP_WIDTH];
  logic [31:0]                 iws [GROUP_WIDTH];
  bit                          timed_out = 1'b0;
  bit                          bad_input = 1'b0;

  always #5 clock = ~clock;

  iq_top #(
    .IQ_DEPTH    (IQ_DEPTH),
    .GROUP_WIDTH (GROUP_WIDTH)
  ) dut0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .flush_i       (flush),
    .dec_valid_i   (dec_valid),
    .dec_count_i   (dec_count),
    .dec_group_i   (dec_group),
    .issue_ready_i (issue_ready),
    .issue_o       (issue),
    .iq_full_o     (iq_full),
    .iq_empty_o    (iq_empty),
    .iq_used_o     (iq_used)
  );

  iq_checker #(
    .DEPTH       (IQ_DEPTH),
    .GROUP_WIDTH (GROUP_WIDTH)
  ) chk0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .flush_i       (flush),
    .dec_valid_i   (dec_valid),
    .dec_count_i   (dec_count),
    .dec_group_i   (dec_group),
    .issue_ready_i (issue_ready),
    .issue_i       (issue),
    .full_i        (iq_full),
    .empty_i       (iq_empty),
    .used_i        (iq_used),
    .test_end_i    (test_end),
    .test_name_i   (test_name),
    .exp_issued_i  (exp_issued),
    .done_i        (run_done),
    .drained_o     (drained),
    .errors_o      (chk_errors)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic random_pc(output logic [31:0] pc);
    int b;
    pc = '0;   // Word aligned.
    for (b = 2; b < 32; b++) begin
      lfsr  = lfsr_next(lfsr);
      pc[b] = lfsr[0];
    end
  endtask

  task automatic step_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic apply_line();
    int          k;
    logic [31:0] pc;
    flush       = v_flush[0];
    dec_valid   = v_valid[0];
    dec_count   = v_count[1:0];
    issue_ready = v_ready[0];
    for (k = 0; k < GROUP_WIDTH; k++) begin
      if (pcs[k] == '0) begin
        random_pc(pc);
      end else begin
        pc = pcs[k];
      end
      dec_group[k].pc        = pc;
      dec_group[k].inst_word = iws[k];
      dec_group[k].serial    = v_serial[k];
    end
  endtask

  task automatic finish_test();
    int cycles;
    flush       = 1'b0;
    dec_valid   = 1'b0;
    issue_ready = 1'b1;
    cycles      = 0;
    while (!(drained && iq_empty) && cycles < TIMEOUT) begin
      step_cycle();
      cycles++;
    end
    if (!(drained && iq_empty)) begin
      $display("Timeout in test %0s: the queue did not drain within %0d cycles",
               test_name, TIMEOUT);
      timed_out = 1'b1;
    end
    test_end = 1'b1;
    step_cycle();
    test_end = 1'b0;
  endtask

  initial begin
    int    fd;
    int    code;
    int    line_no;
    bit    in_test;
    string line;
    reset_n     = 1'b0;
    flush       = 1'b0;
    dec_valid   = 1'b0;
    dec_count   = '0;
    dec_group   = '0;
    issue_ready = 1'b0;
    test_end    = 1'b0;
    run_done    = 1'b0;
    test_name   = '0;
    exp_issued  = '0;
    line_no     = 0;
    in_test     = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    reset_n = 1'b1;
    fd = $fopen("dv/iq_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file dv/iq_vectors.txt");
      bad_input = 1'b1;
    end
    while (fd != 0 && !timed_out && !bad_input && $fgets(line, fd) > 0) begin
      line_no++;
      if (line.len() >= 2 && line.getc(0) == "#") begin
        if (in_test) begin
          finish_test();
        end
        code    = $sscanf(line, "# %s %d", test_name, exp_issued);
        in_test = 1'b1;
        if (code != 2) begin
          $display("Vector line %0d is a test header without a name and count", line_no);
          bad_input = 1'b1;
        end
      end else if (line.len() >= 2 && line.getc(0) != "/") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", v_flush, v_valid,
                       v_count, pcs[0], pcs[1], pcs[2], pcs[3], iws[0], iws[1], iws[2],
                       iws[3], v_serial, v_ready);
        if (code != 13) begin
          $display("Vector line %0d does not hold 13 fields", line_no);
          bad_input = 1'b1;
        end else begin
          apply_line();
          step_cycle();
        end
      end
    end
    if (in_test && !timed_out && !bad_input) begin
      finish_test();
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    run_done = 1'b1;
    step_cycle();
    run_done = 1'b0;
    if (chk_errors == 0 && !timed_out && !bad_input) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/iq_vectors.txt */
// flush dec_valid count pc0 pc1 pc2 pc3 inst0 inst1 inst2 inst3 serial_mask issue_ready (hex)
// count is instructions minus one, pc 0 takes a random pc, "# name n" opens a test issuing n
# single 3
0 1 0 00001000 0 0 0 00000013 0 0 0 0 1
0 1 0 00001004 0 0 0 00100093 0 0 0 0 1
0 1 0 00001008 0 0 0 00200113 0 0 0 0 1
# wide 32
0 1 3 0 0 0 0 00000013 00100093 00200113 00300193 0 1
0 1 3 0 0 0 0 00400213 00500293 00600313 00700393 0 1
0 1 3 0 0 0 0 00800413 00900493 00a00513 00b00593 0 1
0 1 3 0 0 0 0 00c00613 00d00693 00e00713 00f00793 0 1
0 1 3 0 0 0 0 01000813 01100893 01200913 01300993 0 1
0 1 3 0 0 0 0 01400a13 01500a93 01600b13 01700b93 0 1
0 1 3 0 0 0 0 01800c13 01900c93 01a00d13 01b00d93 0 1
0 1 3 0 0 0 0 01c00e13 01d00e93 01e00f13 01f00f93 0 1
# serial 12
0 1 3 0 0 0 0 00400213 0000100f 00500293 00600313 2 1
0 1 3 0 0 0 0 00700393 00800413 00900493 00a00513 0 1
0 1 3 0 0 0 0 00b00593 00c00613 0000100f 00d00693 4 1
# full 16
0 1 3 0 0 0 0 00000013 00100093 00200113 00300193 0 0
0 1 3 0 0 0 0 00400213 00500293 00600313 00700393 0 0
0 1 3 0 0 0 0 00800413 00900493 00a00513 00b00593 0 0
0 1 3 0 0 0 0 00c00613 00d00693 00e00713 00f00793 0 0
0 1 3 0 0 0 0 0dead013 0dead093 0dead113 0dead193 0 0
0 1 3 0 0 0 0 0beef213 0beef293 0beef313 0beef393 0 0
# flush 5
0 1 3 0 0 0 0 00000013 00100093 00200113 00300193 0 1
0 1 3 0 0 0 0 00400213 00500293 00600313 00700393 0 1
1 0 0 0 0 0 0 0 0 0 0 0 1
0 1 0 00002000 0 0 0 00e00713 0 0 0 0 1
# mixed 17
0 1 2 0 0 0 0 00100093 00200113 00300193 0 0 1
0 1 3 0 0 0 0 00400213 0000100f 00500293 00600313 2 0
0 1 1 0 0 0 0 00700393 00800413 0 0 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0000100f 0 0 0 1 1
0 1 3 0 0 0 0 0000100f 00900493 00a00513 0000100f 9 1
0 0 0 0 0 0 0 0 0 0 0 0 1
0 1 2 0 0 0 0 00b00593 00c00613 00d00693 0 0 0

/* hw/circ_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module circ_buf #(
  parameter type T           = logic,
  parameter int  DEPTH       = 16,
  parameter int  GROUP_WIDTH = 4
) (
  input  wire logic                             clock,
  input  wire logic                             reset_n,
  input  wire logic                             flush_i,

  input  wire logic                             ins_enable_i,
  input  wire logic [$clog2(GROUP_WIDTH)-1:0]   ins_count_i,
  input  wire T     [GROUP_WIDTH-1:0]           ins_elements_i,

  input  wire logic                             ext_enable_i,
  input  wire logic [$clog2(GROUP_WIDTH)-1:0]   ext_count_i,
  output logic      [GROUP_WIDTH-1:0]           ext_valid_o,
  output T          [GROUP_WIDTH-1:0]           ext_elements_o,

  output logic                                  full_o,
  output logic                                  empty_o,
  output logic      [$clog2(DEPTH):0]           used_o
);

  localparam int AW = $clog2(DEPTH);

  T                 mem [DEPTH];
  logic [DEPTH-1:0] valid_q;
  logic [DEPTH-1:0] valid_d;
  logic [AW-1:0]    ins_ptr_q;
  logic [AW-1:0]    ext_ptr_q;
  logic [AW:0]      used_q;
  logic [AW:0]      ins_amount;
  logic [AW:0]      ext_amount;
  logic             ext_take;

  assign ext_take = ext_enable_i & ~empty_o;   // Never pop an empty queue.

  assign ins_amount = ins_enable_i ? ((AW+1)'(ins_count_i) + (AW+1)'(1)) : '0;
  assign ext_amount = ext_take ? ((AW+1)'(ext_count_i) + (AW+1)'(1)) : '0;

  always_ff @(posedge clock) begin
    if (ins_enable_i && !flush_i) begin
      for (int k = 0; k < GROUP_WIDTH; k++) begin
        if (k <= int'(ins_count_i)) begin
          mem[ins_ptr_q + AW'(k)] <= ins_elements_i[k];
        end
      end
    end
  end

  // Slots freed by the extract may be refilled by the insert in the same cycle.
  always_comb begin
    valid_d = valid_q;
    if (ext_take) begin
      for (int k = 0; k < GROUP_WIDTH; k++) begin
        if (k <= int'(ext_count_i)) begin
          valid_d[ext_ptr_q + AW'(k)] = 1'b0;
        end
      end
    end
    if (ins_enable_i) begin
      for (int k = 0; k < GROUP_WIDTH; k++) begin
        if (k <= int'(ins_count_i)) begin
          valid_d[ins_ptr_q + AW'(k)] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q   <= '0;
      ins_ptr_q <= '0;
      ext_ptr_q <= '0;
      used_q    <= '0;
    end else if (flush_i) begin
      valid_q   <= '0;
      ins_ptr_q <= '0;
      ext_ptr_q <= '0;
      used_q    <= '0;
    end else begin
      valid_q   <= valid_d;
      ins_ptr_q <= ins_ptr_q + ins_amount[AW-1:0];   // Wraps at DEPTH.
      ext_ptr_q <= ext_ptr_q + ext_amount[AW-1:0];
      used_q    <= used_q + ins_amount - ext_amount;
    end
  end

  always_comb begin
    for (int k = 0; k < GROUP_WIDTH; k++) begin
      ext_elements_o[k] = mem[ext_ptr_q + AW'(k)];
      ext_valid_o[k]    = valid_q[ext_ptr_q + AW'(k)];
    end
  end

  // Full leaves room for one whole group.
  assign full_o  = (used_q > (AW+1)'(DEPTH - GROUP_WIDTH));
  assign empty_o = (used_q == '0);
  assign used_o  = used_q;

endmodule

`default_nettype wire

/* hw/iq_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_issue_select import pip_pkg::*; #(
  parameter int GROUP_WIDTH = 4
) (
  input  wire logic                                 clock,
  input  wire logic                                 reset_n,
  input  wire logic                                 flush_i,
  input  wire logic                                 issue_ready_i,

  input  wire logic      [GROUP_WIDTH-1:0]          head_valid_i,
  input  wire iq_entry_t [GROUP_WIDTH-1:0]          head_entries_i,

  output logic                                      ext_enable_o,
  output logic           [$clog2(GROUP_WIDTH)-1:0]  ext_count_o,
  output issue_bundle_t                             issue_o
);

  localparam int CW = $clog2(GROUP_WIDTH);

  logic [GROUP_WIDTH-1:0]  take;
  logic                    stop;
  logic [ISSUE_W-1:0]      mask_q;
  iq_entry_t [ISSUE_W-1:0] lanes_q;

  always_comb begin
    take        = '0;
    stop        = 1'b0;
    ext_count_o = '0;
    if (head_valid_i[0] && head_entries_i[0].dec_inst.serial) begin
      take[0] = 1'b1;   // Serializing instruction goes alone.
    end else begin
      for (int k = 0; k < GROUP_WIDTH; k++) begin
        if (!head_valid_i[k] || head_entries_i[k].dec_inst.serial) begin
          stop = 1'b1;
        end
        if (!stop) begin
          take[k] = 1'b1;
        end
      end
    end
    if (!issue_ready_i) begin
      take = '0;
    end
    // The run is contiguous from lane 0, so the last lane taken is the count.
    for (int k = 0; k < GROUP_WIDTH; k++) begin
      if (take[k]) begin
        ext_count_o = CW'(k);
      end
    end
  end

  assign ext_enable_o = take[0];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mask_q <= '0;
    end else if (flush_i) begin
      mask_q <= '0;
    end else if (issue_ready_i) begin
      mask_q <= ISSUE_W'(take);   // Zero when nothing was chosen.
    end
  end

  always_ff @(posedge clock) begin
    if (issue_ready_i) begin
      for (int k = 0; k < GROUP_WIDTH; k++) begin
        lanes_q[k] <= head_entries_i[k];
      end
    end
  end

  assign issue_o.entries = lanes_q;
  assign issue_o.valid   = mask_q;

endmodule

`default_nettype wire

/* hw/iq_tagger.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_tagger import pip_pkg::*; #(
  parameter int GROUP_WIDTH = 4
) (
  input  wire logic                                 clock,
  input  wire logic                                 reset_n,
  input  wire logic                                 flush_i,

  input  wire logic                                 dec_valid_i,
  input  wire logic      [$clog2(GROUP_WIDTH)-1:0]  dec_count_i,
  input  wire dec_inst_t [GROUP_WIDTH-1:0]          dec_group_i,

  input  wire logic                                 full_i,

  output logic                                      ins_enable_o,
  output logic           [$clog2(GROUP_WIDTH)-1:0]  ins_count_o,
  output iq_entry_t      [GROUP_WIDTH-1:0]          entries_o
);

  logic [ROB_SLOT_W-1:0] next_slot_q;
  logic [ROB_SLOT_W-1:0] group_size;

  assign ins_enable_o = dec_valid_i & ~full_i;   // Group is dropped while full.
  assign ins_count_o  = dec_count_i;
  assign group_size   = ROB_SLOT_W'(dec_count_i) + ROB_SLOT_W'(1);

  // Lanes past the count get slots too, but the buffer ignores them.
  always_comb begin
    for (int k = 0; k < GROUP_WIDTH; k++) begin
      entries_o[k].dec_inst = dec_group_i[k];
      entries_o[k].rob_slot = next_slot_q + ROB_SLOT_W'(k);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      next_slot_q <= '0;
    end else if (flush_i) begin
      next_slot_q <= '0;
    end else if (ins_enable_o) begin
      next_slot_q <= next_slot_q + group_size;   // Wraps at 32.
    end
  end

endmodule

`default_nettype wire

/* hw/iq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_top import pip_pkg::*; #(
  parameter int IQ_DEPTH    = 16,
  parameter int GROUP_WIDTH = 4
) (
  input  wire logic                                 clock,
  input  wire logic                                 reset_n,
  input  wire logic                                 flush_i,

  input  wire logic                                 dec_valid_i,
  input  wire logic      [$clog2(GROUP_WIDTH)-1:0]  dec_count_i,
  input  wire dec_inst_t [GROUP_WIDTH-1:0]          dec_group_i,

  input  wire logic                                 issue_ready_i,
  output issue_bundle_t                             issue_o,

  output logic                                      iq_full_o,
  output logic                                      iq_empty_o,
  output logic           [$clog2(IQ_DEPTH):0]       iq_used_o
);

  localparam int CW = $clog2(GROUP_WIDTH);

  logic                              ins_enable;
  logic      [CW-1:0]                ins_count;
  iq_entry_t [GROUP_WIDTH-1:0]       ins_entries;
  logic      [GROUP_WIDTH-1:0]       head_valid;
  iq_entry_t [GROUP_WIDTH-1:0]       head_entries;
  logic                              ext_enable;
  logic      [CW-1:0]                ext_count;

  iq_tagger #(
    .GROUP_WIDTH (GROUP_WIDTH)
  ) tagger0 (
    .clock        (clock),
    .reset_n      (reset_n),
    .flush_i      (flush_i),
    .dec_valid_i  (dec_valid_i),
    .dec_count_i  (dec_count_i),
    .dec_group_i  (dec_group_i),
    .full_i       (iq_full_o),
    .ins_enable_o (ins_enable),
    .ins_count_o  (ins_count),
    .entries_o    (ins_entries)
  );

  circ_buf #(
    .T           (iq_entry_t),
    .DEPTH       (IQ_DEPTH),
    .GROUP_WIDTH (GROUP_WIDTH)
  ) buf0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .flush_i        (flush_i),
    .ins_enable_i   (ins_enable),
    .ins_count_i    (ins_count),
    .ins_elements_i (ins_entries),
    .ext_enable_i   (ext_enable),
    .ext_count_i    (ext_count),
    .ext_valid_o    (head_valid),
    .ext_elements_o (head_entries),
    .full_o         (iq_full_o),
    .empty_o        (iq_empty_o),
    .used_o         (iq_used_o)
  );

  iq_issue_select #(
    .GROUP_WIDTH (GROUP_WIDTH)
  ) select0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .flush_i        (flush_i),
    .issue_ready_i  (issue_ready_i),
    .head_valid_i   (head_valid),
    .head_entries_i (head_entries),
    .ext_enable_o   (ext_enable),
    .ext_count_o    (ext_count),
    .issue_o        (issue_o)
  );

endmodule

`default_nettype wire

/* hw/pip_pkg.sv */
`default_nettype none

package pip_pkg;

  localparam int XLEN       = 32;
  localparam int ROB_SLOT_W = 5;   // 32-slot reorder buffer.
  localparam int ISSUE_W    = 4;   // Lanes in one issue bundle.

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst_word;
    logic            serial;       // Must issue alone.
  } dec_inst_t;

  typedef struct packed {
    dec_inst_t             dec_inst;
    logic [ROB_SLOT_W-1:0] rob_slot;
  } iq_entry_t;

  // Lane 0 holds the oldest instruction of the bundle.
  typedef struct packed {
    iq_entry_t [ISSUE_W-1:0] entries;
    logic      [ISSUE_W-1:0] valid;
  } issue_bundle_t;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module iq_tb -o iq_sim
./obj_dir/iq_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failure"

/* src.f */
hw/pip_pkg.sv
hw/circ_buf.sv
hw/iq_tagger.sv
hw/iq_issue_select.sv
hw/iq_top.sv
dv/iq_checker.sv
dv/iq_tb.sv
